//--- build.f
hdl/video_pkg.sv
hdl/video_if.sv
hdl/video_timing.sv
hdl/video_txt.sv
hdl/video_bck.sv
hdl/video_colmix.sv
hdl/video_top.sv
tests/tb_video.sv

//--- hdl/video_bck.sv
`default_nettype none

module video_bck (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pxl_cen,
    beam_if.layer               beam,
    cpu_if.bck                  cpu,
    output video_pkg::bck_pxl_t bck_pxl
);

localparam int tile_bits = $clog2(video_pkg::tile_size);
localparam int col_bits  = $clog2(video_pkg::map_cols);
localparam int row_bits  = $clog2(video_pkg::map_rows);
localparam int map_size  = video_pkg::map_cols * video_pkg::map_rows;

video_pkg::bck_pxl_t blk_ram [map_size];

logic                         blk_we;
logic                         scroll_we;
logic [7:0]                   scroll;
logic [7:0]                   eff_h;
logic [row_bits+col_bits-1:0] rd_idx;
video_pkg::bck_pxl_t          blk_q;

assign blk_we    = cpu.we && cpu.bck_cs && (cpu.addr < 11'(map_size));
assign scroll_we = cpu.we && cpu.bck_cs && (cpu.addr == video_pkg::scroll_addr);

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        scroll <= 8'd0;
    end else if (scroll_we) begin
        scroll <= cpu.data;
    end
end

always_ff @(posedge clk) begin
    if (blk_we) begin
        blk_ram[cpu.addr[row_bits+col_bits-1:0]] <= cpu.data[4:0];
    end
end

// Scrolled column wraps around the 256 pixel map
assign eff_h  = beam.h[7:0] + scroll;
assign rd_idx = {beam.v[tile_bits +: row_bits], eff_h[tile_bits +: col_bits]};

always_ff @(posedge clk) begin
    if (pxl_cen) begin
        blk_q <= blk_ram[rd_idx];
    end
end

// Extra stage keeps pace with the text layer
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        bck_pxl <= '0;
    end else if (pxl_cen) begin
        bck_pxl <= blk_q;
    end
end

a_wr_decode: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(scroll_we && blk_we)
) else $error("CPU write %0h hits both scroll and block RAM", cpu.addr);

endmodule

`default_nettype wire

//--- hdl/video_colmix.sv
`default_nettype none

module video_colmix (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pxl_cen,
    beam_if.layer               beam,
    prog_if.colmix              prog,
    input  video_pkg::txt_pxl_t txt_pxl,
    input  video_pkg::bck_pxl_t bck_pxl,
    output logic                hb,
    output logic                vb,
    output logic [2:0]          red,
    output logic [2:0]          green,
    output logic [2:0]          blue
);

localparam int pal_len = video_pkg::txt_pal_len + video_pkg::bck_pal_len;

// Text entries first, background after them
video_pkg::rgb_t pal [pal_len];

logic [7:0]      pal_ofs;
logic [7:0]      bck_ofs;
logic            txt_pal_we;
logic            bck_pal_we;
logic [5:0]      wr_idx;
logic [5:0]      rd_idx;
logic [2:0]      hb_sr;
logic [2:0]      vb_sr;
logic            blank;
video_pkg::rgb_t col_q;

assign pal_ofs    = prog.addr - video_pkg::pal_base;
assign bck_ofs    = pal_ofs - video_pkg::bck_pal_ofs;
assign txt_pal_we = prog.we && (pal_ofs < 8'(video_pkg::txt_pal_len));
assign bck_pal_we = prog.we && (bck_ofs < 8'(video_pkg::bck_pal_len));
assign wr_idx     = txt_pal_we ? 6'(pal_ofs) : 6'(video_pkg::txt_pal_len) + 6'(bck_ofs);

always_ff @(posedge clk) begin
    if (txt_pal_we || bck_pal_we) begin
        pal[wr_idx] <= prog.data;
    end
end

// Text wins over background when its pixel is set
assign rd_idx = txt_pxl.visible ? 6'(txt_pxl.color)
                                : 6'(video_pkg::txt_pal_len) + 6'(bck_pxl);

assign blank = hb_sr[1] | vb_sr[1];     // Blanking of the pixel being loaded

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        hb_sr <= 3'd0;
        vb_sr <= 3'd0;
        col_q <= '0;
    end else if (pxl_cen) begin
        hb_sr <= {hb_sr[1:0], beam.hb};
        vb_sr <= {vb_sr[1:0], beam.vb};
        col_q <= blank ? '0 : pal[rd_idx];
    end
end

assign hb    = hb_sr[2];
assign vb    = vb_sr[2];
assign red   = col_q.red;
assign green = col_q.green;
assign blue  = {col_q.blue, 1'b0};     // LSB is always zero

a_blank_black: assert property (
    @(posedge clk) disable iff (!arst_n)
    (hb || vb) |-> (red == 3'd0 && green == 3'd0 && blue == 3'd0)
) else $error("colour %0h/%0h/%0h during blanking", red, green, blue);

endmodule

`default_nettype wire

//--- hdl/video_if.sv
`default_nettype none

// Beam position and blankings, driven by the timing module
interface beam_if;
    logic [8:0] h;
    logic [8:0] v;
    logic       hb;
    logic       vb;

    modport timing (
        output h,
        output v,
        output hb,
        output vb
    );

    modport layer (
        input h,
        input v,
        input hb,
        input vb
    );
endinterface

// CPU write bus, one location per strobe
interface cpu_if;
    logic [10:0] addr;
    logic [ 7:0] data;
    logic        we;
    logic        txt_cs;
    logic        bck_cs;

    modport txt (
        input addr,
        input data,
        input we,
        input txt_cs
    );

    modport bck (
        input addr,
        input data,
        input we,
        input bck_cs
    );
endinterface

// Font and palette download
interface prog_if;
    logic [7:0] addr;
    logic [7:0] data;
    logic       we;

    modport txt    (input addr, input data, input we);
    modport colmix (input addr, input data, input we);
endinterface

`default_nettype wire

//--- hdl/video_pkg.sv
`default_nettype none

package video_pkg;

// Tile geometry, shared by the text and background layers
localparam int tile_size = 8;   // Pixels per tile edge
localparam int map_cols  = 32;
localparam int map_rows  = 32;

// Download port regions
localparam logic [7:0] font_base   = 8'h00;
localparam int         font_len    = 128;    // 16 characters of 8 rows
localparam logic [7:0] pal_base    = 8'h80;  // Text palette starts here
localparam logic [7:0] bck_pal_ofs = 8'h20;  // Background palette, from pal_base
localparam int         txt_pal_len = 16;
localparam int         bck_pal_len = 32;

// CPU side
localparam logic [10:0] scroll_addr = 11'h400;

// Palette entry field widths
localparam int red_w   = 3;
localparam int green_w = 3;
localparam int blue_w  = 2;     // Blue LSB is dropped

typedef struct packed {
    logic                           visible;
    logic [$clog2(txt_pal_len)-1:0] color;
} txt_pxl_t;

// Background colour index
typedef logic [$clog2(bck_pal_len)-1:0] bck_pxl_t;

typedef struct packed {
    logic [red_w-1:0]   red;
    logic [green_w-1:0] green;
    logic [blue_w-1:0]  blue;
} rgb_t;

endpackage

`default_nettype wire

//--- hdl/video_timing.sv
`default_nettype none

module video_timing #(
    parameter int h_active = 256,
    parameter int h_total  = 320,
    parameter int v_active = 224,
    parameter int v_total  = 262
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   pxl_cen,
    beam_if.timing beam
);

logic [8:0] h_nxt;
logic [8:0] v_nxt;
logic       h_wrap;
logic       v_wrap;

assign h_wrap = beam.h == 9'(h_total - 1);
assign v_wrap = beam.v == 9'(v_total - 1);
assign h_nxt  = h_wrap ? 9'd0 : beam.h + 9'd1;

// Vertical count moves once per line
always_comb begin
    v_nxt = beam.v;
    if (h_wrap) begin
        v_nxt = v_wrap ? 9'd0 : beam.v + 9'd1;
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        beam.h  <= 9'd0;
        beam.v  <= 9'd0;
        beam.hb <= 1'b0;
        beam.vb <= 1'b0;
    end else if (pxl_cen) begin
        beam.h  <= h_nxt;
        beam.v  <= v_nxt;
        // Blankings come from the next count so they line up with h and v
        beam.hb <= h_nxt >= 9'(h_active);
        beam.vb <= v_nxt >= 9'(v_active);
    end
end

a_h_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    beam.h < 9'(h_total)
) else $error("h count %0h past line end", beam.h);

a_v_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    beam.v < 9'(v_total)
) else $error("v count %0h past frame end", beam.v);

endmodule

`default_nettype wire

//--- hdl/video_top.sv
`default_nettype none

module video_top #(
    parameter int h_active = 256,
    parameter int h_total  = 320,
    parameter int v_active = 224,
    parameter int v_total  = 262
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pxl_cen,
    // CPU writes
    input  logic [10:0] cpu_addr,
    input  logic [ 7:0] cpu_data,
    input  logic        cpu_we,
    input  logic        txt_cs,
    input  logic        bck_cs,
    // Font and palette download
    input  logic [ 7:0] prog_addr,
    input  logic [ 7:0] prog_data,
    input  logic        prog_we,
    // Video out
    output logic        hb,
    output logic        vb,
    output logic [ 2:0] red,
    output logic [ 2:0] green,
    output logic [ 2:0] blue    // LSB is always zero
);

beam_if beam ();
cpu_if  cpu ();
prog_if prog ();

video_pkg::txt_pxl_t txt_pxl;
video_pkg::bck_pxl_t bck_pxl;

assign cpu.addr   = cpu_addr;
assign cpu.data   = cpu_data;
assign cpu.we     = cpu_we;
assign cpu.txt_cs = txt_cs;
assign cpu.bck_cs = bck_cs;

assign prog.addr = prog_addr;
assign prog.data = prog_data;
assign prog.we   = prog_we;

video_timing #(
    .h_active ( h_active ),
    .h_total  ( h_total  ),
    .v_active ( v_active ),
    .v_total  ( v_total  )
) u_timing (
    .clk     ( clk     ),
    .arst_n  ( arst_n  ),
    .pxl_cen ( pxl_cen ),
    .beam    ( beam    )
);

video_txt u_txt (.clk(clk), .arst_n(arst_n), .pxl_cen(pxl_cen), .beam(beam),
                 .cpu(cpu), .prog(prog), .txt_pxl(txt_pxl));

video_bck u_bck (.clk(clk), .arst_n(arst_n), .pxl_cen(pxl_cen), .beam(beam),
                 .cpu(cpu), .bck_pxl(bck_pxl));

video_colmix u_colmix (
    .clk     ( clk     ),
    .arst_n  ( arst_n  ),
    .pxl_cen ( pxl_cen ),
    .beam    ( beam    ),
    .prog    ( prog    ),
    .txt_pxl ( txt_pxl ),
    .bck_pxl ( bck_pxl ),
    .hb      ( hb      ),
    .vb      ( vb      ),
    .red     ( red     ),
    .green   ( green   ),
    .blue    ( blue    )
);

endmodule

`default_nettype wire

//--- hdl/video_txt.sv
`default_nettype none

module video_txt (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pxl_cen,
    beam_if.layer               beam,
    cpu_if.txt                  cpu,
    prog_if.txt                 prog,
    output video_pkg::txt_pxl_t txt_pxl
);

localparam int tile_bits = $clog2(video_pkg::tile_size);
localparam int col_bits  = $clog2(video_pkg::map_cols);
localparam int row_bits  = $clog2(video_pkg::map_rows);
localparam int map_size  = video_pkg::map_cols * video_pkg::map_rows;
localparam int font_bits = $clog2(video_pkg::font_len);

// Tile byte: colour in the upper nibble, character in the lower
logic [7:0] tile_ram [map_size];
logic [7:0] font_ram [video_pkg::font_len];

logic                         tile_we;
logic                         font_we;
logic [7:0]                   font_ofs;
logic [row_bits+col_bits-1:0] rd_idx;

logic [7:0]           tile_q;
logic [tile_bits-1:0] row_q;
logic [tile_bits-1:0] col_q;
logic [7:0]           font_row;

assign tile_we  = cpu.we && cpu.txt_cs && (cpu.addr < 11'(map_size));
assign font_ofs = prog.addr - video_pkg::font_base;  // Wraps below the base
assign font_we  = prog.we && (font_ofs < 8'(video_pkg::font_len));

// Tile under the beam
assign rd_idx = {beam.v[tile_bits +: row_bits], beam.h[tile_bits +: col_bits]};

always_ff @(posedge clk) begin
    if (tile_we) begin
        tile_ram[cpu.addr[row_bits+col_bits-1:0]] <= cpu.data;
    end
    if (font_we) begin
        font_ram[font_ofs[font_bits-1:0]] <= prog.data;
    end
end

// First stage, tile fetch with the pixel offsets riding along
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        tile_q <= tile_ram[rd_idx];
        row_q  <= beam.v[tile_bits-1:0];
        col_q  <= beam.h[tile_bits-1:0];
    end
end

assign font_row = font_ram[{tile_q[3:0], row_q}];   // 8 rows per character

// Second stage
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        txt_pxl <= '0;
    end else if (pxl_cen) begin
        txt_pxl.visible <= font_row[~col_q];    // Bit 7 is the leftmost pixel
        txt_pxl.color   <= tile_q[7:4];
    end
end

endmodule

`default_nettype wire

//--- tests/tb_video.sv
`default_nettype none

module tb_video;

timeunit 1ns;
timeprecision 1ps;

localparam int h_active   = 64;
localparam int h_total    = 80;
localparam int v_active   = 32;
localparam int v_total    = 40;
localparam int max_cycles = 6 * h_total * v_total * 2 + 2000;

logic        clk;
logic        arst_n;
logic        pxl_cen;
logic [10:0] cpu_addr;
logic [ 7:0] cpu_data;
logic        cpu_we;
logic        txt_cs;
logic        bck_cs;
logic [ 7:0] prog_addr;
logic [ 7:0] prog_data;
logic        prog_we;
logic        hb;
logic        vb;
logic [ 2:0] red;
logic [ 2:0] green;
logic [ 2:0] blue;

// Reference copies of everything written into the DUT
logic [7:0] tile_m [1024];
logic [4:0] blk_m  [1024];
logic [7:0] font_m [128];
logic [7:0] pal_m  [48];     // 16 text entries, then 32 background
logic [7:0] scroll_m;

int         seed;
int         cycles;
int         ticks;           // pxl_cen ticks since reset
int         mh, mv, mframe;  // Beam position
int         oh, ov, oframe;  // Position now on the outputs
logic [7:0] exp_rgb;
logic       exp_hb;
logic       exp_vb;
logic       col_check;

video_top #(
    .h_active ( h_active ),
    .h_total  ( h_total  ),
    .v_active ( v_active ),
    .v_total  ( v_total  )
) video_top_i (
    .clk       ( clk       ),
    .arst_n    ( arst_n    ),
    .pxl_cen   ( pxl_cen   ),
    .cpu_addr  ( cpu_addr  ),
    .cpu_data  ( cpu_data  ),
    .cpu_we    ( cpu_we    ),
    .txt_cs    ( txt_cs    ),
    .bck_cs    ( bck_cs    ),
    .prog_addr ( prog_addr ),
    .prog_data ( prog_data ),
    .prog_we   ( prog_we   ),
    .hb        ( hb        ),
    .vb        ( vb        ),
    .red       ( red       ),
    .green     ( green     ),
    .blue      ( blue      )
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(negedge clk) pxl_cen <= ~pxl_cen;   // Pixel rate is half the clock

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
endtask

// Expected palette entry for an active pixel
function automatic logic [7:0] pixel_rgb(input int h, input int v);
    logic [7:0] tile;
    logic [7:0] glyph;
    int         sh;
    tile  = tile_m[(v / 8) * 32 + h / 8];
    glyph = font_m[int'(tile[3:0]) * 8 + v % 8];
    if (glyph[7 - h % 8]) begin
        return pal_m[int'(tile[7:4])];      // Text on top
    end
    sh = (h + int'(scroll_m)) % 256;
    return pal_m[16 + int'(blk_m[(v / 8) * 32 + sh / 8])];
endfunction

always @(posedge clk or negedge arst_n) begin : beam_model
    int nh;
    int nv;
    if (!arst_n) begin
        ticks   <= 0;
        mh      <= 0;
        mv      <= 0;
        mframe  <= 0;
        oh      <= 0;
        ov      <= 0;
        oframe  <= 0;
        exp_rgb <= 8'h00;
    end else if (pxl_cen) begin
        ticks <= ticks + 1;
        if (mh == h_total - 1) begin
            mh <= 0;
            if (mv == v_total - 1) begin
                mv     <= 0;
                mframe <= mframe + 1;
            end else begin
                mv <= mv + 1;
            end
        end else begin
            mh <= mh + 1;
        end
        // Outputs trail the beam by 3 ticks
        nh = oh;
        nv = ov;
        if (ticks >= 3) begin
            if (nh == h_total - 1) begin
                nh = 0;
                if (nv == v_total - 1) begin
                    nv = 0;
                    oframe <= oframe + 1;
                end else begin
                    nv = nv + 1;
                end
            end else begin
                nh = nh + 1;
            end
        end
        oh      <= nh;
        ov      <= nv;
        exp_rgb <= (nh < h_active && nv < v_active) ? pixel_rgb(nh, nv) : 8'h00;
    end
end

assign exp_hb    = oh >= h_active;
assign exp_vb    = ov >= v_active;
assign col_check = oframe >= 1 && !exp_hb && !exp_vb;  // Frame 0 holds load traffic

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
        fail_run($sformatf("Simulation timed out after %0d clock cycles", cycles));
    end
end

a_reset_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
    ticks == 0 |-> (!hb && !vb && red == 3'd0 && green == 3'd0 && blue == 3'd0)
) else fail_run($sformatf("[ERROR] after reset hb=%h vb=%h red=%h green=%h blue=%h, expected 0",
    $sampled(hb), $sampled(vb), $sampled(red), $sampled(green), $sampled(blue)));

a_hb: assert property (@(posedge clk) disable iff (!arst_n) hb == exp_hb)
    else fail_run($sformatf("[ERROR] hb=%h expected %h", $sampled(hb), $sampled(exp_hb)));

a_vb: assert property (@(posedge clk) disable iff (!arst_n) vb == exp_vb)
    else fail_run($sformatf("[ERROR] vb=%h expected %h", $sampled(vb), $sampled(exp_vb)));

a_blank_black: assert property (
    @(posedge clk) disable iff (!arst_n)
    (exp_hb || exp_vb) |-> (red == 3'd0 && green == 3'd0 && blue == 3'd0)
) else fail_run($sformatf("[ERROR] blanked colour red=%h green=%h blue=%h, expected 0",
    $sampled(red), $sampled(green), $sampled(blue)));

a_red: assert property (@(posedge clk) disable iff (!arst_n)
    col_check |-> red == exp_rgb[7:5])
    else fail_run($sformatf("[ERROR] red=%h expected %h at h=%0d v=%0d",
        $sampled(red), $sampled(exp_rgb[7:5]), $sampled(oh), $sampled(ov)));

a_green: assert property (@(posedge clk) disable iff (!arst_n)
    col_check |-> green == exp_rgb[4:2])
    else fail_run($sformatf("[ERROR] green=%h expected %h at h=%0d v=%0d",
        $sampled(green), $sampled(exp_rgb[4:2]), $sampled(oh), $sampled(ov)));

a_blue: assert property (@(posedge clk) disable iff (!arst_n)
    col_check |-> blue == {exp_rgb[1:0], 1'b0})
    else fail_run($sformatf("[ERROR] blue=%h expected %h at h=%0d v=%0d",
        $sampled(blue), $sampled({exp_rgb[1:0], 1'b0}), $sampled(oh), $sampled(ov)));

task automatic cpu_write(input logic to_txt, input logic [10:0] addr, input logic [7:0] data);
    @(negedge clk);
    cpu_addr = addr;
    cpu_data = data;
    cpu_we   = 1'b1;
    txt_cs   = to_txt;
    bck_cs   = !to_txt;
    if (to_txt) begin
        tile_m[addr[9:0]] = data;
    end else if (addr == video_pkg::scroll_addr) begin
        scroll_m = data;
    end else begin
        blk_m[addr[9:0]] = data[4:0];
    end
    @(negedge clk);
    cpu_we = 1'b0;
    txt_cs = 1'b0;
    bck_cs = 1'b0;
endtask

task automatic prog_write(input logic [7:0] addr, input logic [7:0] data);
    @(negedge clk);
    prog_addr = addr;
    prog_data = data;
    prog_we   = 1'b1;
    if (addr < 8'h80) begin
        font_m[addr[6:0]] = data;
    end else if (addr < 8'h90) begin
        pal_m[int'(addr) - 'h80] = data;
    end else if (addr >= 8'hA0 && addr < 8'hC0) begin
        pal_m[16 + int'(addr) - 'hA0] = data;
    end
    @(negedge clk);
    prog_we = 1'b0;
endtask

task automatic load_font(input logic clear);
    for (int i = 0; i < 128; i++) begin
        prog_write(8'(i), clear ? 8'h00 : 8'($random(seed)));
    end
endtask

task automatic load_palette();
    for (int i = 0; i < 16; i++) begin
        prog_write(8'(8'h80 + i), 8'($random(seed)));
    end
    for (int i = 0; i < 32; i++) begin
        prog_write(8'(8'hA0 + i), 8'($random(seed)));
    end
endtask

// Rows 0 to 3 cover the visible lines, all 32 columns for any scroll
task automatic load_blocks();
    for (int i = 0; i < 4 * 32; i++) begin
        cpu_write(1'b0, 11'(i), 8'($random(seed)));
    end
endtask

task automatic load_tiles();
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < h_active / 8; c++) begin
            cpu_write(1'b1, 11'(r * 32 + c), 8'($random(seed)));
        end
    end
endtask

task automatic wait_line(input int frame, input int line);
    @(negedge clk);
    while (!(mframe == frame && mv == line)) begin
        @(negedge clk);
    end
endtask

initial begin
    arst_n    = 1'b0;
    pxl_cen   = 1'b0;
    cpu_addr  = 11'h000;
    cpu_data  = 8'h00;
    cpu_we    = 1'b0;
    txt_cs    = 1'b0;
    bck_cs    = 1'b0;
    prog_addr = 8'h00;
    prog_data = 8'h00;
    prog_we   = 1'b0;
    scroll_m  = 8'h00;
    cycles    = 0;
    seed      = 32'h7011;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    load_font(1'b1);    // Background only in frame 1
    load_palette();
    load_blocks();
    load_tiles();
    wait_line(1, v_active + 1);
    load_font(1'b0);    // Text over background from frame 2
    load_tiles();
    wait_line(2, v_active + 1);
    cpu_write(1'b0, video_pkg::scroll_addr, 8'($random(seed)));
    wait_line(3, v_active + 1);
    load_palette();     // New colours from frame 4
    wait_line(5, 0);
    $display("*** TEST PASSED ***");
    $finish;
end

endmodule

`default_nettype wire
